//--- design/ip_rx_pkg.sv
package ip_rx_pkg;

    // one byte of the input or output stream
    typedef logic [7:0] byte_t;

    // 16-bit header fields and the running checksum
    typedef logic [15:0] word16_t;

    typedef logic [31:0] ip_addr_t;

    typedef logic [12:0] frag_off_t;

    // byte position within a frame, same width as the total length field
    typedef logic [15:0] ptr_t;

    // TRIM drops bytes past the stated length, DROP eats a rejected frame
    typedef enum logic [1:0] {
        HEADER,
        PAYLOAD,
        TRIM,
        DROP
    } rx_state_t;

    localparam logic [3:0] IP_VERSION = 4'd4;
    localparam logic [3:0] IP_IHL = 4'd5;

    // fixed header size, no options
    localparam ptr_t IP_HDR_BYTES = 16'd20;

    // a valid header sums to all ones in ones' complement
    localparam word16_t CSUM_GOOD = 16'hffff;

endpackage

//--- design/ip_hdr_csum.sv
module ip_hdr_csum (
    input  logic               clk,
    input  logic               rst,
    input  logic               clear,
    input  logic               byte_en,
    input  ip_rx_pkg::ptr_t    hdr_index,
    input  ip_rx_pkg::byte_t   data,
    output ip_rx_pkg::word16_t sum
);

    ip_rx_pkg::word16_t sum_q;
    ip_rx_pkg::word16_t base;
    ip_rx_pkg::word16_t word;
    logic [16:0]        raw;

    // sum already includes the byte of this cycle
    always_comb begin
        base = clear ? '0 : sum_q;
        // even index is the upper byte of a 16-bit word
        word = hdr_index[0] ? {8'h00, data} : {data, 8'h00};
        raw = {1'b0, base} + {1'b0, word};
        if (byte_en) begin
            // end-around carry
            sum = raw[15:0] + {15'd0, raw[16]};
        end else begin
            sum = base;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sum_q <= '0;
        end else begin
            sum_q <= sum;
        end
    end

endmodule

//--- design/ip_hdr_fields.sv
module ip_hdr_fields (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 byte_en,
    input  ip_rx_pkg::ptr_t      hdr_index,
    input  ip_rx_pkg::byte_t     data,
    output logic [3:0]           version,
    output logic [3:0]           ihl,
    output logic [5:0]           dscp,
    output logic [1:0]           ecn,
    output ip_rx_pkg::word16_t   length,
    output ip_rx_pkg::word16_t   identification,
    output logic [2:0]           flags,
    output ip_rx_pkg::frag_off_t frag_offset,
    output ip_rx_pkg::byte_t     ttl,
    output ip_rx_pkg::byte_t     protocol,
    output ip_rx_pkg::word16_t   hdr_checksum,
    output ip_rx_pkg::ip_addr_t  src_ip,
    output ip_rx_pkg::ip_addr_t  dst_ip
);

    // network byte order, most significant byte first
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            version <= '0;
            ihl <= '0;
            dscp <= '0;
            ecn <= '0;
            length <= '0;
            identification <= '0;
            flags <= '0;
            frag_offset <= '0;
            ttl <= '0;
            protocol <= '0;
            hdr_checksum <= '0;
            src_ip <= '0;
            dst_ip <= '0;
        end else if (byte_en) begin
            case (hdr_index)
                16'd0: {version, ihl} <= data;
                16'd1: {dscp, ecn} <= data;
                16'd2: length[15:8] <= data;
                16'd3: length[7:0] <= data;
                16'd4: identification[15:8] <= data;
                16'd5: identification[7:0] <= data;
                // flags share a byte with the top of the fragment offset
                16'd6: {flags, frag_offset[12:8]} <= data;
                16'd7: frag_offset[7:0] <= data;
                16'd8: ttl <= data;
                16'd9: protocol <= data;
                16'd10: hdr_checksum[15:8] <= data;
                16'd11: hdr_checksum[7:0] <= data;
                16'd12: src_ip[31:24] <= data;
                16'd13: src_ip[23:16] <= data;
                16'd14: src_ip[15:8] <= data;
                16'd15: src_ip[7:0] <= data;
                16'd16: dst_ip[31:24] <= data;
                16'd17: dst_ip[23:16] <= data;
                16'd18: dst_ip[15:8] <= data;
                16'd19: dst_ip[7:0] <= data;
                default: begin
                end
            endcase
        end
    end

endmodule

//--- design/ip_rx_ctrl.sv
module ip_rx_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    input  logic               in_last,
    input  logic               in_user,
    input  logic [3:0]         version,
    input  logic [3:0]         ihl,
    input  ip_rx_pkg::word16_t length,
    input  ip_rx_pkg::word16_t sum,
    input  logic               hdr_ready,
    input  logic               pl_ready,
    output logic               in_ready,
    output logic               hdr_clear,
    output logic               hdr_byte_en,
    output ip_rx_pkg::ptr_t    hdr_index,
    output logic               hdr_valid,
    output logic               pl_push,
    output logic               pl_last,
    output logic               pl_user,
    output logic               pl_mark_last,
    output logic               pl_mark_user,
    output logic               busy,
    output logic               err_hdr_early,
    output logic               err_payload_early,
    output logic               err_bad_header,
    output logic               err_bad_csum
);

    ip_rx_pkg::rx_state_t state;
    ip_rx_pkg::rx_state_t state_n;
    ip_rx_pkg::ptr_t      ptr;
    ip_rx_pkg::ptr_t      ptr_n;
    logic                 xfer;
    logic                 bad_hdr;
    logic                 end_len;
    logic                 in_ready_n;
    logic                 hdr_valid_n;
    logic                 hdr_early_n;
    logic                 pl_early_n;
    logic                 bad_hdr_n;
    logic                 bad_csum_n;

    assign xfer = in_valid && in_ready;
    assign hdr_index = ptr;
    assign hdr_byte_en = xfer && (state == ip_rx_pkg::HEADER);
    // restart the checksum on the first byte of a frame
    assign hdr_clear = (state == ip_rx_pkg::HEADER) && (ptr == '0);
    assign bad_hdr = (version != ip_rx_pkg::IP_VERSION) || (ihl != ip_rx_pkg::IP_IHL)
                     || (length <= ip_rx_pkg::IP_HDR_BYTES);
    assign end_len = (ptr + 16'd1) == length;

    always_comb begin
        state_n = state;
        ptr_n = ptr;
        hdr_valid_n = hdr_valid && !hdr_ready;
        hdr_early_n = 1'b0;
        pl_early_n = 1'b0;
        bad_hdr_n = 1'b0;
        bad_csum_n = 1'b0;
        pl_push = 1'b0;
        pl_last = 1'b0;
        pl_user = 1'b0;
        pl_mark_last = 1'b0;
        pl_mark_user = 1'b0;
        case (state)
            ip_rx_pkg::HEADER: begin
                if (xfer) begin
                    ptr_n = ptr + 16'd1;
                    if (in_last) begin
                        hdr_early_n = 1'b1;
                        ptr_n = '0;
                    end else if (ptr == ip_rx_pkg::IP_HDR_BYTES - 16'd1) begin
                        // sum here already covers the 20th byte
                        if (bad_hdr) begin
                            bad_hdr_n = 1'b1;
                            state_n = ip_rx_pkg::DROP;
                        end else if (sum != ip_rx_pkg::CSUM_GOOD) begin
                            bad_csum_n = 1'b1;
                            state_n = ip_rx_pkg::DROP;
                        end else begin
                            hdr_valid_n = 1'b1;
                            state_n = ip_rx_pkg::PAYLOAD;
                        end
                    end
                end
            end
            ip_rx_pkg::PAYLOAD: begin
                if (xfer) begin
                    ptr_n = ptr + 16'd1;
                    pl_push = 1'b1;
                    pl_user = in_user;
                    if (in_last) begin
                        pl_last = 1'b1;
                        pl_mark_last = 1'b1;
                        if (!end_len) begin
                            // frame shorter than its length field
                            pl_user = 1'b1;
                            pl_early_n = 1'b1;
                        end
                        state_n = ip_rx_pkg::HEADER;
                        ptr_n = '0;
                    end else if (end_len) begin
                        // buffer holds this byte until the frame really ends
                        pl_last = 1'b1;
                        state_n = ip_rx_pkg::TRIM;
                    end
                end
            end
            ip_rx_pkg::TRIM: begin
                if (xfer && in_last) begin
                    pl_mark_last = 1'b1;
                    pl_mark_user = in_user;
                    state_n = ip_rx_pkg::HEADER;
                    ptr_n = '0;
                end
            end
            default: begin
                if (xfer && in_last) begin
                    state_n = ip_rx_pkg::HEADER;
                    ptr_n = '0;
                end
            end
        endcase

        case (state_n)
            // a pending header blocks the next frame
            ip_rx_pkg::HEADER: in_ready_n = !hdr_valid_n;
            ip_rx_pkg::PAYLOAD: in_ready_n = pl_ready;
            default: in_ready_n = 1'b1;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ip_rx_pkg::HEADER;
            ptr <= '0;
            in_ready <= 1'b0;
            hdr_valid <= 1'b0;
            busy <= 1'b0;
            err_hdr_early <= 1'b0;
            err_payload_early <= 1'b0;
            err_bad_header <= 1'b0;
            err_bad_csum <= 1'b0;
        end else begin
            state <= state_n;
            ptr <= ptr_n;
            in_ready <= in_ready_n;
            hdr_valid <= hdr_valid_n;
            busy <= (state_n != ip_rx_pkg::HEADER) || (ptr_n != '0);
            err_hdr_early <= hdr_early_n;
            err_payload_early <= pl_early_n;
            err_bad_header <= bad_hdr_n;
            err_bad_csum <= bad_csum_n;
        end
    end

    // header valid only follows a complete 20-byte header
    assert property (@(posedge clk) disable iff (rst)
        $rose(hdr_valid) |->
            $past(hdr_byte_en && !in_last && hdr_index == ip_rx_pkg::IP_HDR_BYTES - 16'd1));

    assert property (@(posedge clk) disable iff (rst)
        $onehot0({err_hdr_early, err_payload_early, err_bad_header, err_bad_csum}));

endmodule

//--- design/ip_payload_buf.sv
module ip_payload_buf (
    input  logic             clk,
    input  logic             rst,
    input  logic             push,
    input  ip_rx_pkg::byte_t data,
    input  logic             last,
    input  logic             user,
    input  logic             mark_last,
    input  logic             mark_user,
    output logic             ready,
    output ip_rx_pkg::byte_t out_data,
    output logic             out_valid,
    output logic             out_last,
    output logic             out_user,
    input  logic             out_ready
);

    logic             out_v;
    logic             out_v_n;
    logic             tmp_v;
    logic             tmp_v_n;
    logic             hold;
    logic             hold_n;
    logic             pop;
    ip_rx_pkg::byte_t out_d;
    ip_rx_pkg::byte_t out_d_n;
    ip_rx_pkg::byte_t tmp_d;
    ip_rx_pkg::byte_t tmp_d_n;
    logic             out_l;
    logic             out_l_n;
    logic             out_u;
    logic             out_u_n;
    logic             tmp_l;
    logic             tmp_l_n;
    logic             tmp_u;
    logic             tmp_u_n;

    // a held last byte waits for its mark before leaving
    assign out_valid = out_v && !(hold && !tmp_v);
    assign out_data = out_d;
    assign out_last = out_l;
    assign out_user = out_u;
    assign pop = out_valid && out_ready;

    always_comb begin
        out_v_n = out_v;
        tmp_v_n = tmp_v;
        out_d_n = out_d;
        out_l_n = out_l;
        out_u_n = out_u;
        tmp_d_n = tmp_d;
        tmp_l_n = tmp_l;
        tmp_u_n = tmp_u;
        hold_n = hold;
        if (pop) begin
            if (tmp_v) begin
                out_d_n = tmp_d;
                out_l_n = tmp_l;
                out_u_n = tmp_u;
                tmp_v_n = 1'b0;
            end else begin
                out_v_n = 1'b0;
            end
        end
        if (push) begin
            if (!out_v_n) begin
                out_v_n = 1'b1;
                out_d_n = data;
                out_l_n = last;
                out_u_n = user;
            end else begin
                tmp_v_n = 1'b1;
                tmp_d_n = data;
                tmp_l_n = last;
                tmp_u_n = user;
            end
            if (last) begin
                hold_n = 1'b1;
            end
        end
        // marks go to the newest entry
        if (tmp_v_n) begin
            tmp_l_n = tmp_l_n || mark_last;
            tmp_u_n = tmp_u_n || mark_user;
        end else begin
            out_l_n = out_l_n || mark_last;
            out_u_n = out_u_n || mark_user;
        end
        if (mark_last) begin
            hold_n = 1'b0;
        end
        // room for a push next cycle whatever the sink does
        ready = !(out_v_n && tmp_v_n);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_v <= 1'b0;
            tmp_v <= 1'b0;
            hold <= 1'b0;
        end else begin
            out_v <= out_v_n;
            tmp_v <= tmp_v_n;
            hold <= hold_n;
        end
    end

    always_ff @(posedge clk) begin
        out_d <= out_d_n;
        out_l <= out_l_n;
        out_u <= out_u_n;
        tmp_d <= tmp_d_n;
        tmp_l <= tmp_l_n;
        tmp_u <= tmp_u_n;
    end

    assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=>
            out_valid && $stable({out_data, out_last, out_user}));

endmodule

//--- design/ip_rx.sv
module ip_rx (
    input  logic                 clk,
    input  logic                 rst,
    input  ip_rx_pkg::byte_t     in_data,
    input  logic                 in_valid,
    input  logic                 in_last,
    input  logic                 in_user,
    output logic                 in_ready,
    output logic                 hdr_valid,
    input  logic                 hdr_ready,
    output logic [3:0]           version,
    output logic [3:0]           ihl,
    output logic [5:0]           dscp,
    output logic [1:0]           ecn,
    output ip_rx_pkg::word16_t   length,
    output ip_rx_pkg::word16_t   identification,
    output logic [2:0]           flags,
    output ip_rx_pkg::frag_off_t frag_offset,
    output ip_rx_pkg::byte_t     ttl,
    output ip_rx_pkg::byte_t     protocol,
    output ip_rx_pkg::word16_t   hdr_checksum,
    output ip_rx_pkg::ip_addr_t  src_ip,
    output ip_rx_pkg::ip_addr_t  dst_ip,
    output ip_rx_pkg::byte_t     out_data,
    output logic                 out_valid,
    output logic                 out_last,
    output logic                 out_user,
    input  logic                 out_ready,
    output logic                 busy,
    output logic                 err_hdr_early,
    output logic                 err_payload_early,
    output logic                 err_bad_header,
    output logic                 err_bad_csum
);

    logic               hdr_clear;
    logic               hdr_byte_en;
    ip_rx_pkg::ptr_t    hdr_index;
    ip_rx_pkg::word16_t sum;
    logic               pl_push;
    logic               pl_last;
    logic               pl_user;
    logic               pl_mark_last;
    logic               pl_mark_user;
    logic               pl_ready;

    ip_rx_ctrl ctrl_i (
        .clk(clk),
        .rst(rst),
        .in_valid(in_valid),
        .in_last(in_last),
        .in_user(in_user),
        .version(version),
        .ihl(ihl),
        .length(length),
        .sum(sum),
        .hdr_ready(hdr_ready),
        .pl_ready(pl_ready),
        .in_ready(in_ready),
        .hdr_clear(hdr_clear),
        .hdr_byte_en(hdr_byte_en),
        .hdr_index(hdr_index),
        .hdr_valid(hdr_valid),
        .pl_push(pl_push),
        .pl_last(pl_last),
        .pl_user(pl_user),
        .pl_mark_last(pl_mark_last),
        .pl_mark_user(pl_mark_user),
        .busy(busy),
        .err_hdr_early(err_hdr_early),
        .err_payload_early(err_payload_early),
        .err_bad_header(err_bad_header),
        .err_bad_csum(err_bad_csum)
    );

    ip_hdr_fields fields_i (
        .clk(clk),
        .rst(rst),
        .byte_en(hdr_byte_en),
        .hdr_index(hdr_index),
        .data(in_data),
        .version(version),
        .ihl(ihl),
        .dscp(dscp),
        .ecn(ecn),
        .length(length),
        .identification(identification),
        .flags(flags),
        .frag_offset(frag_offset),
        .ttl(ttl),
        .protocol(protocol),
        .hdr_checksum(hdr_checksum),
        .src_ip(src_ip),
        .dst_ip(dst_ip)
    );

    ip_hdr_csum csum_i (
        .clk(clk),
        .rst(rst),
        .clear(hdr_clear),
        .byte_en(hdr_byte_en),
        .hdr_index(hdr_index),
        .data(in_data),
        .sum(sum)
    );

    ip_payload_buf buf_i (
        .clk(clk),
        .rst(rst),
        .push(pl_push),
        .data(in_data),
        .last(pl_last),
        .user(pl_user),
        .mark_last(pl_mark_last),
        .mark_user(pl_mark_user),
        .ready(pl_ready),
        .out_data(out_data),
        .out_valid(out_valid),
        .out_last(out_last),
        .out_user(out_user),
        .out_ready(out_ready)
    );

endmodule

//--- verif/ip_rx_tb_model.svh
`ifndef IP_RX_TB_MODEL_SVH
`define IP_RX_TB_MODEL_SVH

// frame kinds
localparam int K_VALID = 0;
localparam int K_EXTRA = 1;
localparam int K_EARLY = 2;
localparam int K_BAD_HDR = 3;
localparam int K_BAD_CSUM = 4;
localparam int K_HDR_EARLY = 5;

// galois lfsr, one step per random bit taken
logic [31:0] lfsr = 32'd76309;

logic [7:0]   hb [20];
logic [7:0]   fr [$];
logic         fin_user;
logic [9:0]   exp_out [$];
logic [159:0] exp_hdr;
int           exp_nhdr;
// hdr_early, payload_early, bad_header, bad_csum
int           exp_err [4];

function automatic logic [31:0] rnd(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        r = {r[30:0], lfsr[0]};
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return r;
endfunction

// ones' complement sum of the ten header words
function automatic logic [15:0] ones_sum();
    logic [31:0] s;
    s = '0;
    for (int i = 0; i < 20; i += 2) begin
        s = s + {16'd0, hb[i], hb[i + 1]};
    end
    s = {16'd0, s[15:0]} + {16'd0, s[31:16]};
    s = {16'd0, s[15:0]} + {16'd0, s[31:16]};
    return s[15:0];
endfunction

task automatic build_frame(input int kind);
    int          plen;
    int          carried;
    int          sub;
    logic [15:0] len;
    logic [15:0] cs;
    logic        lst;
    logic        usr;
    fr.delete();
    exp_out.delete();
    exp_err = '{0, 0, 0, 0};
    exp_nhdr = 0;
    exp_hdr = '0;
    fin_user = 1'b0;
    plen = 1 + int'(rnd(5)) % 24;
    if (kind == K_EARLY && plen < 2) begin
        plen = 2;
    end
    for (int i = 0; i < 20; i++) begin
        hb[i] = 8'(rnd(8));
    end
    hb[0] = 8'h45;
    len = 16'(20 + plen);
    if (kind == K_BAD_HDR) begin
        sub = int'(rnd(2));
        if (sub == 0) begin
            hb[0][7:4] = 4'(rnd(4));
            if (hb[0][7:4] == 4'd4) begin
                hb[0][7:4] = 4'd6;
            end
        end else if (sub == 1) begin
            hb[0][3:0] = 4'(rnd(4));
            if (hb[0][3:0] == 4'd5) begin
                hb[0][3:0] = 4'd7;
            end
        end else begin
            len = 16'(int'(rnd(5)) % 21);
        end
    end
    hb[2] = len[15:8];
    hb[3] = len[7:0];
    hb[10] = 8'h00;
    hb[11] = 8'h00;
    cs = ~ones_sum();
    hb[10] = cs[15:8];
    // one bit off keeps the sum away from all ones
    hb[11] = (kind == K_BAD_CSUM) ? (cs[7:0] ^ 8'h01) : cs[7:0];
    if (kind == K_HDR_EARLY) begin
        carried = int'(rnd(5)) % 20;
        for (int i = 0; i <= carried; i++) begin
            fr.push_back(hb[i]);
        end
        exp_err[0] = 1;
    end else begin
        for (int i = 0; i < 20; i++) begin
            fr.push_back(hb[i]);
            exp_hdr = {exp_hdr[151:0], hb[i]};
        end
        case (kind)
            K_VALID: carried = plen;
            K_EXTRA: carried = plen + 1 + int'(rnd(2));
            K_EARLY: carried = 1 + int'(rnd(5)) % (plen - 1);
            default: carried = 1 + int'(rnd(2));
        endcase
        for (int i = 0; i < carried; i++) begin
            fr.push_back(8'(rnd(8)));
        end
        if (kind == K_EXTRA || kind == K_EARLY) begin
            fin_user = rnd(1) != 0;
        end
        if (kind == K_BAD_HDR) begin
            exp_err[2] = 1;
        end else if (kind == K_BAD_CSUM) begin
            exp_err[3] = 1;
        end else begin
            exp_nhdr = 1;
            if (kind == K_EARLY) begin
                exp_err[1] = 1;
            end
            for (int i = 0; i < carried && i < plen; i++) begin
                lst = (i == carried - 1) || (i == plen - 1);
                usr = lst && ((kind == K_EARLY) || (kind == K_EXTRA && fin_user));
                exp_out.push_back({usr, lst, fr[20 + i]});
            end
        end
    end
endtask

`endif

//--- verif/ip_rx_tb.sv
module ip_rx_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int FRAMES = 200;
    localparam int TIMEOUT = 2000;

    logic                 clk;
    logic                 rst;
    ip_rx_pkg::byte_t     in_data;
    logic                 in_valid;
    logic                 in_last;
    logic                 in_user;
    logic                 in_ready;
    logic                 hdr_valid;
    logic                 hdr_ready;
    logic [3:0]           version;
    logic [3:0]           ihl;
    logic [5:0]           dscp;
    logic [1:0]           ecn;
    ip_rx_pkg::word16_t   length;
    ip_rx_pkg::word16_t   identification;
    logic [2:0]           flags;
    ip_rx_pkg::frag_off_t frag_offset;
    ip_rx_pkg::byte_t     ttl;
    ip_rx_pkg::byte_t     protocol;
    ip_rx_pkg::word16_t   hdr_checksum;
    ip_rx_pkg::ip_addr_t  src_ip;
    ip_rx_pkg::ip_addr_t  dst_ip;
    ip_rx_pkg::byte_t     out_data;
    logic                 out_valid;
    logic                 out_last;
    logic                 out_user;
    logic                 out_ready;
    logic                 busy;
    logic                 err_hdr_early;
    logic                 err_payload_early;
    logic                 err_bad_header;
    logic                 err_bad_csum;

    logic [9:0]   out_q [$];
    logic [159:0] hdr_q [$];
    int           err_cnt [4];

    `include "ip_rx_tb_model.svh"

    ip_rx ip_rx_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // sink ready is chosen and transfers are recorded before the rising edge
    always @(negedge clk) begin
        if (!rst) begin
            out_ready = rnd(2) != 0;
            hdr_ready = rnd(2) != 0;
            if (out_valid && out_ready) begin
                out_q.push_back({out_user, out_last, out_data});
            end
            if (hdr_valid && hdr_ready) begin
                hdr_q.push_back({version, ihl, dscp, ecn, length, identification, flags,
                                 frag_offset, ttl, protocol, hdr_checksum, src_ip, dst_ip});
            end
            if (err_hdr_early) begin
                err_cnt[0]++;
            end
            if (err_payload_early) begin
                err_cnt[1]++;
            end
            if (err_bad_header) begin
                err_cnt[2]++;
            end
            if (err_bad_csum) begin
                err_cnt[3]++;
            end
        end
    end

    task automatic stop_run(input string why);
        $display("sim failed");
        $fatal(1, "%s", why);
    endtask

    task automatic check_val(input string name, input logic [159:0] exp, input logic [159:0] act);
        if (exp !== act) begin
            $display("FAIL time %0t %s expected %0h actual %0h", $time, name, exp, act);
            stop_run("a DUT output differs from the model");
        end
    endtask

    task automatic send_frame();
        int t;
        for (int i = 0; i < fr.size(); i++) begin
            @(negedge clk);
            if (rnd(2) == 32'd3) begin
                in_valid = 1'b0;
                @(negedge clk);
            end
            in_valid = 1'b1;
            in_data = fr[i];
            in_last = (i == fr.size() - 1);
            in_user = in_last ? fin_user : 1'b0;
            t = 0;
            while (!in_ready) begin
                t++;
                if (t > TIMEOUT) begin
                    stop_run("input stalled, in_ready stayed low too long");
                end else begin
                    @(negedge clk);
                end
            end
        end
        @(negedge clk);
        in_valid = 1'b0;
        in_last = 1'b0;
        in_user = 1'b0;
    endtask

    task automatic wait_frame();
        int t;
        t = 0;
        while (hdr_q.size() < exp_nhdr || out_q.size() < exp_out.size()
               || err_cnt[0] < exp_err[0] || err_cnt[1] < exp_err[1]
               || err_cnt[2] < exp_err[2] || err_cnt[3] < exp_err[3]) begin
            t++;
            if (t > TIMEOUT) begin
                stop_run("frame results did not arrive in time");
            end else begin
                @(posedge clk);
            end
        end
    endtask

    task automatic compare_frame();
        check_val("hdr_valid transfers", 160'(exp_nhdr), 160'(hdr_q.size()));
        if (exp_nhdr == 1) begin
            check_val("header fields", exp_hdr, hdr_q[0]);
        end
        check_val("out_valid transfers", 160'(exp_out.size()), 160'(out_q.size()));
        for (int i = 0; i < exp_out.size(); i++) begin
            check_val($sformatf("{out_user,out_last,out_data} byte %0d", i),
                      160'(exp_out[i]), 160'(out_q[i]));
        end
        check_val("err_hdr_early pulses", 160'(exp_err[0]), 160'(err_cnt[0]));
        check_val("err_payload_early pulses", 160'(exp_err[1]), 160'(err_cnt[1]));
        check_val("err_bad_header pulses", 160'(exp_err[2]), 160'(err_cnt[2]));
        check_val("err_bad_csum pulses", 160'(exp_err[3]), 160'(err_cnt[3]));
        hdr_q.delete();
        out_q.delete();
        err_cnt = '{0, 0, 0, 0};
    endtask

    initial begin
        int kind;
        int t;
        rst = 1'b1;
        in_data = '0;
        in_valid = 1'b0;
        in_last = 1'b0;
        in_user = 1'b0;
        out_ready = 1'b0;
        hdr_ready = 1'b0;
        err_cnt = '{0, 0, 0, 0};
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int f = 0; f < FRAMES; f++) begin
            kind = int'(rnd(3));
            if (kind > K_HDR_EARLY) begin
                kind = K_VALID;
            end
            build_frame(kind);
            send_frame();
            wait_frame();
            compare_frame();
        end
        t = 0;
        while (out_valid || hdr_valid) begin
            t++;
            if (t > TIMEOUT) begin
                stop_run("DUT did not drain after the final frame");
            end else begin
                @(negedge clk);
            end
        end
        repeat (2) @(negedge clk);
        check_val("late header transfers", '0, 160'(hdr_q.size()));
        check_val("late payload transfers", '0, 160'(out_q.size()));
        check_val("late error pulses", '0,
                  160'(err_cnt[0] + err_cnt[1] + err_cnt[2] + err_cnt[3]));
        check_val("busy", '0, 160'(busy));
        $display("sim passed");
        $finish;
    end

endmodule

//--- ip_rx.f
+incdir+verif
design/ip_rx_pkg.sv
design/ip_hdr_csum.sv
design/ip_hdr_fields.sv
design/ip_rx_ctrl.sv
design/ip_payload_buf.sv
design/ip_rx.sv
verif/ip_rx_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the ip_rx testbench with Verilator
set -u

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module ip_rx_tb -Mdir obj_dir -f ip_rx.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/Vip_rx_tb
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0
